// File: run_sim.sh
#!/bin/bash
# Build and run the SD host testbench, then judge the log
verilator --binary --timing --top-module sd_host_tb -f sd_host_top.f -o sd_host_sim \
  && ./obj_dir/sd_host_sim | tee sim.log \
  && grep -q ">>> PASS" sim.log \
  && ! grep -q ">>> FAIL" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: sd_host_top.f
+incdir+verilog
verilog/sd_pkg.sv
verilog/sd_spi_if.sv
verilog/sd_buf_if.sv
verilog/sd_spi_shifter.sv
verilog/sd_crc.sv
verilog/sd_block_buffer.sv
verilog/sd_apb_regs.sv
verilog/sd_controller.sv
verilog/sd_host_top.sv
test/sd_card_model.sv
test/sd_host_tb.sv

// File: test/sd_card_model.sv
`timescale 1ns/1ps
`include "sd_params.svh"

module sd_card_model #(
  parameter logic [31:0] read_addr = 32'h0,
  parameter logic [31:0] poison_addr = 32'h0
) (
  input  logic cs,
  input  logic sck,
  input  logic mosi,
  output logic miso
);

  logic [7:0] mem [bit [40:0]];
  logic [7:0] frame [6];
  logic [7:0] wr_data [514];
  logic [7:0] resp_q [$];
  logic [7:0] rx;
  logic [7:0] tx;
  logic [31:0] wr_addr;
  int bits, frame_len, mode, data_cnt, cmd_count, acmd41_tries;
  int errors, slow_checks, fast_checks, rises;
  logic saw_cmd16, fast_phase;
  realtime last_rise;
  int init_seq [11] = '{0, 8, 55, 41, 55, 41, 55, 41, 55, 41, 16};

  function automatic logic [6:0] crc7_step(input logic [6:0] crc, input logic [7:0] d);
    logic [6:0] c;
    c = crc;
    for (int i = 7; i >= 0; i--) c = {c[5:0], 1'b0} ^ ((c[6] ^ d[i]) ? 7'h09 : 7'h00);
    return c;
  endfunction

  function automatic logic [15:0] crc16_step(input logic [15:0] crc, input logic [7:0] d);
    logic [15:0] c;
    c = crc;
    for (int i = 7; i >= 0; i--) c = {c[14:0], 1'b0} ^ ((c[15] ^ d[i]) ? 16'h1021 : 16'h0);
    return c;
  endfunction

  initial begin
    logic [31:0] a;
    miso = 1'b1;
    tx = 8'hff;
    {bits, frame_len, mode, data_cnt, cmd_count, acmd41_tries} = '0;
    {errors, slow_checks, fast_checks, rises} = '0;
    saw_cmd16 = 1'b0;
    fast_phase = 1'b0;
    last_rise = 0.0;
    // Every address bit feeds the preloaded pattern
    for (int k = 0; k < 2; k++) begin
      a = k == 0 ? read_addr : poison_addr;
      for (int i = 0; i < `SD_BLOCK_BYTES; i++) begin
        mem[{a, 9'(i)}] = 8'(i * 29) ^ a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ {7'd0, i[8]};
      end
    end
  end

  task automatic handle_cmd();
    logic [6:0]  crc;
    logic [15:0] dcrc;
    logic [31:0] arg;
    int idx;
    crc = '0;
    for (int i = 0; i < 5; i++) crc = crc7_step(crc, frame[i]);
    assert (frame[5] == {crc, 1'b1}) else begin
      $display("MISMATCH %0t: command CRC7 byte %h, expected %h", $time, frame[5], {crc, 1'b1});
      errors++;
    end
    idx = int'(frame[0][5:0]);
    arg = {frame[1], frame[2], frame[3], frame[4]};
    if (cmd_count < 11) begin
      assert (idx == init_seq[cmd_count]) else begin
        $display("MISMATCH %0t: command %0d was CMD%0d, expected CMD%0d",
                 $time, cmd_count, idx, init_seq[cmd_count]);
        errors++;
      end
    end else begin
      assert (idx == 17 || idx == 24) else begin
        $display("Card got unexpected command CMD%0d after init", idx);
        errors++;
      end
    end
    cmd_count++;
    resp_q.push_back(8'hff);
    case (idx)
      0, 55: resp_q.push_back(8'h01);
      8: begin
        resp_q.push_back(8'h01);
        resp_q.push_back(8'h00);
        resp_q.push_back(8'h00);
        resp_q.push_back({4'h0, arg[11:8]});
        resp_q.push_back(arg[7:0]);
      end
      41: begin
        acmd41_tries++;
        resp_q.push_back(acmd41_tries <= 3 ? 8'h01 : 8'h00);
      end
      16: begin
        resp_q.push_back(8'h00);
        saw_cmd16 = 1'b1;
      end
      17: begin
        dcrc = '0;
        resp_q.push_back(8'h00);
        resp_q.push_back(8'hff);
        resp_q.push_back(8'hfe);
        for (int i = 0; i < `SD_BLOCK_BYTES; i++) begin
          resp_q.push_back(mem[{arg, 9'(i)}]);
          dcrc = crc16_step(dcrc, mem[{arg, 9'(i)}]);
        end
        // Poisoned block goes out with a bad CRC
        if (arg == poison_addr) dcrc = ~dcrc;
        resp_q.push_back(dcrc[15:8]);
        resp_q.push_back(dcrc[7:0]);
      end
      24: begin
        resp_q.push_back(8'h00);
        wr_addr = arg;
        mode = 1;
      end
      default: resp_q.push_back(8'h04);
    endcase
  endtask

  task automatic finish_write();
    logic [15:0] dcrc;
    dcrc = '0;
    for (int i = 0; i < `SD_BLOCK_BYTES; i++) begin
      dcrc = crc16_step(dcrc, wr_data[i]);
      mem[{wr_addr, 9'(i)}] = wr_data[i];
    end
    assert ({wr_data[512], wr_data[513]} == dcrc) else begin
      $display("MISMATCH %0t: write CRC16 %h, expected %h",
               $time, {wr_data[512], wr_data[513]}, dcrc);
      errors++;
    end
    mode = 0;
    resp_q.push_back(8'h05);
    resp_q.push_back(8'h00);
    resp_q.push_back(8'h00);
  endtask

  task automatic take_byte(input logic [7:0] b);
    case (mode)
      0: begin
        if (frame_len > 0 || b[7:6] == 2'b01) begin
          frame[frame_len] = b;
          frame_len++;
          if (frame_len == 6) begin
            frame_len = 0;
            handle_cmd();
          end
        end
      end
      1: if (b == 8'hfe) begin
        mode = 2;
        data_cnt = 0;
      end
      default: begin
        wr_data[data_cnt] = b;
        data_cnt++;
        if (data_cnt == 514) finish_write();
      end
    endcase
  endtask

  always @(posedge sck) begin
    // Only rises inside one byte are a clean period apart
    if (rises % 8 != 0) begin
      if (fast_phase) begin
        fast_checks++;
        assert ($realtime - last_rise > `SD_FAST_DIV * 10.0 - 0.5 &&
                $realtime - last_rise < `SD_FAST_DIV * 10.0 + 0.5) else begin
          $display("MISMATCH %0t: fast SCK period %0.1f ns", $time, $realtime - last_rise);
          errors++;
        end
      end else begin
        slow_checks++;
        assert ($realtime - last_rise > `SD_SLOW_DIV * 10.0 - 0.5 &&
                $realtime - last_rise < `SD_SLOW_DIV * 10.0 + 0.5) else begin
          $display("MISMATCH %0t: slow SCK period %0.1f ns", $time, $realtime - last_rise);
          errors++;
        end
      end
    end
    rises++;
    last_rise = $realtime;
    if (!cs) begin
      rx = {rx[6:0], mosi};
      bits++;
      if (bits == 8) begin
        bits = 0;
        take_byte(rx);
      end
    end else begin
      bits = 0;
    end
  end

  always @(negedge sck) begin
    if (!cs) begin
      if (bits == 0) tx = resp_q.size() > 0 ? resp_q.pop_front() : 8'hff;
      miso = tx[7];
      tx = {tx[6:0], 1'b1};
    end
  end

  always @(posedge cs) begin
    resp_q.delete();
    miso = 1'b1;
    if (saw_cmd16) fast_phase = 1'b1;
  end

endmodule

// File: test/sd_host_tb.sv
`timescale 1ns/1ps
`include "sd_params.svh"

module sd_host_tb;

  localparam logic [31:0] wr_addr = 32'h0000_0123;
  localparam logic [31:0] rd_addr = 32'h0001_0040;
  localparam logic [31:0] bad_addr = 32'h0000_0bad;
  // Init bytes and four transfers at their dividers with a margin of two
  localparam real slow_byte_ns = (8.0 * `SD_SLOW_DIV + 2.0) * 10.0;
  localparam real fast_byte_ns = (8.0 * `SD_FAST_DIV + 2.0) * 10.0;
  localparam real run_limit_ns = 2.0 * (110.0 * slow_byte_ns + 4.0 * 540.0 * fast_byte_ns);

  logic        clock_100M;
  logic        reset;
  logic [11:0] paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        cs, sck, mosi, miso;
  logic [31:0] lfsr;
  logic [31:0] exp_word [128];
  int          errors;

  sd_host_top uut (.*);

  sd_card_model #(.read_addr(rd_addr), .poison_addr(bad_addr)) card (
    .cs(cs), .sck(sck), .mosi(mosi), .miso(miso)
  );

  initial begin
    clock_100M = 1'b0;
    forever #5 clock_100M = ~clock_100M;
  end

  initial begin
    #(run_limit_ns);
    $display("Timeout: the run did not finish within %0.0f ns", run_limit_ns);
    $display(">>> FAIL");
    $finish;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? (s >> 1) ^ 32'h8020_0003 : s >> 1;
  endfunction

  task automatic next_word(output logic [31:0] w);
    w = '0;
    for (int i = 0; i < 32; i++) begin
      w = {w[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic apb_access(input logic [11:0] a, input logic wr, input logic [31:0] d,
                            output logic [31:0] rdata, output logic err);
    @(negedge clock_100M);
    paddr = a;
    pwrite = wr;
    pwdata = d;
    psel = 1'b1;
    @(negedge clock_100M);
    penable = 1'b1;
    #1;
    rdata = prdata;
    err = pslverr;
    assert (pready === 1'b1) else begin
      $display("MISMATCH %0t: pready %b in the access cycle", $time, pready);
      errors++;
    end
    @(negedge clock_100M);
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic expect_err(input logic [11:0] a, input logic wr, input logic [31:0] d,
                            input logic want);
    logic [31:0] r;
    logic e;
    apb_access(a, wr, d, r, e);
    assert (e == want) else begin
      $display("MISMATCH %0t: pslverr %b at offset %h, expected %b", $time, e, a, want);
      errors++;
    end
  endtask

  task automatic check_status(input logic [5:0] want);
    logic [31:0] r;
    logic e;
    apb_access(`SD_REG_STATUS, 1'b0, 32'd0, r, e);
    assert (r[5:0] == want) else begin
      $display("MISMATCH %0t: STATUS %b, expected %b", $time, r[5:0], want);
      errors++;
    end
  endtask

  // Poll STATUS while the masked bits still hold the given value
  task automatic wait_status(input logic [5:0] mask, input logic [5:0] wait_val);
    logic [31:0] r;
    logic e;
    int polls;
    polls = 0;
    do begin
      apb_access(`SD_REG_STATUS, 1'b0, 32'd0, r, e);
      polls++;
    end while ((r[5:0] & mask) == wait_val && polls < 400000);
    if (polls >= 400000) begin
      $display("STATUS never reached the expected state");
      errors++;
    end
  endtask

  task automatic read_block(input logic [31:0] a, input logic [5:0] want);
    logic [31:0] r;
    logic e;
    apb_access(`SD_REG_ADDR, 1'b1, a, r, e);
    apb_access(`SD_REG_CTRL, 1'b1, 32'd1, r, e);
    wait_status(6'b100000, 6'b100000);
    check_status(want);
  endtask

  task automatic compare_window(input logic [31:0] a);
    logic [31:0] r;
    logic [31:0] w;
    logic e;
    for (int i = 0; i < 128; i++) begin
      w = {card.mem[{a, 9'(4 * i + 3)}], card.mem[{a, 9'(4 * i + 2)}],
           card.mem[{a, 9'(4 * i + 1)}], card.mem[{a, 9'(4 * i)}]};
      apb_access(12'(`SD_DATA_BASE + 4 * i), 1'b0, 32'd0, r, e);
      assert (r === w) else begin
        $display("MISMATCH %0t: read word %0d is %h, expected %h", $time, i, r, w);
        errors++;
      end
    end
  endtask

  initial begin
    logic [31:0] r;
    logic e;
    int cmds;
    errors = 0;
    lfsr = 32'hfa46;
    reset = 1'b1;
    paddr = '0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    pwdata = '0;
    repeat (16) @(posedge clock_100M);
    @(negedge clock_100M);
    reset = 1'b0;

    assert (cs === 1'b1 && sck === 1'b0 && mosi === 1'b1 &&
            pready === 1'b1 && pslverr === 1'b0) else begin
      $display("MISMATCH %0t: after reset cs %b sck %b mosi %b pready %b pslverr %b",
               $time, cs, sck, mosi, pready, pslverr);
      errors++;
    end
    check_status(6'b100000);
    wait_status(6'b011000, 6'b000000);
    check_status(6'b010000);
    expect_err(12'h00c, 1'b0, 32'd0, 1'b1);
    expect_err(`SD_DATA_BASE, 1'b0, 32'd0, 1'b0);
    expect_err(`SD_REG_CTRL, 1'b1, 32'd0, 1'b0);

    // Block write with LFSR data
    for (int i = 0; i < 128; i++) begin
      next_word(exp_word[i]);
      apb_access(12'(`SD_DATA_BASE + 4 * i), 1'b1, exp_word[i], r, e);
    end
    apb_access(`SD_REG_ADDR, 1'b1, wr_addr, r, e);
    cmds = card.cmd_count;
    apb_access(`SD_REG_CTRL, 1'b1, 32'd2, r, e);
    expect_err(`SD_DATA_BASE, 1'b0, 32'd0, 1'b1);
    expect_err(`SD_REG_CTRL, 1'b1, 32'd1, 1'b1);
    wait_status(6'b100000, 6'b100000);
    check_status(6'b010000);
    assert (card.cmd_count == cmds + 1) else begin
      $display("MISMATCH %0t: card saw %0d commands, expected %0d",
               $time, card.cmd_count - cmds, 1);
      errors++;
    end
    for (int n = 0; n < `SD_BLOCK_BYTES; n++) begin
      assert (card.mem[{wr_addr, 9'(n)}] === exp_word[n / 4][(n % 4) * 8 +: 8]) else begin
        $display("MISMATCH %0t: stored byte %0d is %h", $time, n, card.mem[{wr_addr, 9'(n)}]);
        errors++;
      end
    end

    read_block(rd_addr, 6'b010000);
    compare_window(rd_addr);
    read_block(bad_addr, 6'b010001);
    read_block(rd_addr, 6'b010000);
    compare_window(rd_addr);

    assert (card.slow_checks > 0 && card.fast_checks > 0) else begin
      $display("SCK period was not measured in both init and transfer phases");
      errors++;
    end

    $display("Errors: testbench %0d, card model %0d", errors, card.errors);
    if (errors == 0 && card.errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: verilog/sd_apb_regs.sv
`timescale 1ns/1ps
`include "sd_params.svh"

module sd_apb_regs (
  input  logic               clock_100M,
  input  logic               reset,
  input  logic [11:0]        paddr,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  logic [31:0]        pwdata,
  input  sd_pkg::sd_status_t status,
  input  logic [31:0]        buf_rdata,
  output logic [31:0]        prdata,
  output logic               pready,
  output logic               pslverr,
  output sd_pkg::sd_op_t     op,
  output logic               op_valid,
  output logic [31:0]        block_addr,
  output logic [6:0]         buf_addr,
  output logic [31:0]        buf_wdata,
  output logic               buf_we
);

  logic access;
  logic is_ctrl;
  logic is_addr;
  logic is_status;
  logic in_data;
  logic start_req;

  assign access = psel && penable;
  assign is_ctrl = paddr == `SD_REG_CTRL;
  assign is_addr = paddr == `SD_REG_ADDR;
  assign is_status = paddr == `SD_REG_STATUS;
  assign in_data = (paddr & 12'he00) == `SD_DATA_BASE;

  // CTRL bit 0 starts a read, bit 1 a write
  assign start_req = access && pwrite && is_ctrl && (pwdata[1:0] != 2'b00);
  assign op_valid = start_req && status.init_done && !status.busy;

  always_comb begin
    if (pwdata[0]) op = sd_pkg::op_read;
    else if (pwdata[1]) op = sd_pkg::op_write;
    else op = sd_pkg::op_none;
  end

  assign pready = 1'b1;
  assign pslverr = access && (!(is_ctrl || is_addr || is_status || in_data) ||
                              (in_data && status.busy) ||
                              (start_req && status.busy));

  always_ff @(posedge clock_100M) begin
    if (reset) begin
      block_addr <= '0;
    end else if (access && pwrite && is_addr) begin
      block_addr <= pwdata;
    end
  end

  // Data window word index taken straight from the offset
  assign buf_addr = paddr[8:2];
  assign buf_wdata = pwdata;
  assign buf_we = access && pwrite && in_data && !status.busy;

  always_comb begin
    prdata = '0;
    if (is_addr) prdata = block_addr;
    else if (is_status) prdata = {26'd0, status};
    else if (in_data && !status.busy) prdata = buf_rdata;
  end

endmodule

// File: verilog/sd_block_buffer.sv
`timescale 1ns/1ps
`include "sd_params.svh"

module sd_block_buffer (
  input  logic        clock_100M,
  input  logic [6:0]  buf_addr,
  input  logic [31:0] buf_wdata,
  input  logic        buf_we,
  output logic [31:0] buf_rdata,
  sd_buf_if.buffer    bus
);

  logic [31:0] mem [`SD_BLOCK_BYTES / 4];
  logic [4:0]  lane;

  // Byte n lives in word n/4, lane n mod 4
  assign lane = {bus.addr[1:0], 3'b000};

  always_ff @(posedge clock_100M) begin
    if (buf_we) begin
      mem[buf_addr] <= buf_wdata;
    end else if (bus.we) begin
      mem[bus.addr[8:2]][lane +: 8] <= bus.wdata;
    end
  end

  assign buf_rdata = mem[buf_addr];
  assign bus.rdata = mem[bus.addr[8:2]][lane +: 8];

endmodule

// File: verilog/sd_buf_if.sv
`timescale 1ns/1ps

interface sd_buf_if;
  logic [8:0] addr;
  logic [7:0] wdata;
  logic       we;
  logic [7:0] rdata;

  modport controller (output addr, wdata, we, input rdata);
  modport buffer (input addr, wdata, we, output rdata);
endinterface

// File: verilog/sd_controller.sv
`timescale 1ns/1ps
`include "sd_params.svh"

module sd_controller (
  input  logic               clock_100M,
  input  logic               reset,
  input  sd_pkg::sd_op_t     op,
  input  logic               op_valid,
  input  logic [31:0]        block_addr,
  output sd_pkg::sd_status_t status,
  sd_spi_if.controller       spi,
  sd_buf_if.controller       bus
);

  localparam int init_bytes = `SD_INIT_CLOCKS / 8;

  sd_pkg::sd_state_t state;
  sd_pkg::sd_cmd_t   cmd;
  logic [12:0] cnt;
  logic [7:0]  retry;
  logic        pending;
  logic        launch;
  logic        fast;
  logic        init_done;
  logic        init_error;
  logic        resp_error;
  logic        timeout_error;
  logic        crc_error;
  logic [31:0] addr_q;
  logic [7:0]  last_rx;
  logic [31:0] cmd_arg;
  logic [7:0]  tx_next;
  logic [7:0]  rx;
  logic        crc_clear;
  logic [6:0]  crc7;
  logic [15:0] crc16;

  assign rx = spi.rx_byte;
  assign status = '{busy: state != sd_pkg::st_idle, init_done: init_done,
                    init_error: init_error, resp_error: resp_error,
                    timeout_error: timeout_error, crc_error: crc_error};

  // Next byte goes out as soon as the shifter has returned the last one
  assign launch = !pending && state != sd_pkg::st_idle;
  assign spi.start = launch;
  assign spi.tx_byte = tx_next;
  assign spi.fast = fast;
  assign spi.cs_active = state != sd_pkg::st_idle && state != sd_pkg::st_init;

  assign bus.addr = cnt[8:0];
  assign bus.wdata = rx;
  assign bus.we = spi.done && state == sd_pkg::st_rdata;

  always_comb begin
    case (cmd)
      sd_pkg::cmd8:   cmd_arg = 32'h0000_01aa;
      sd_pkg::acmd41: cmd_arg = 32'h4000_0000;
      sd_pkg::cmd16:  cmd_arg = 32'(`SD_BLOCK_BYTES);
      sd_pkg::cmd17,
      sd_pkg::cmd24:  cmd_arg = addr_q;
      default:        cmd_arg = '0;
    endcase
  end

  always_comb begin
    tx_next = 8'hff;
    case (state)
      sd_pkg::st_cmd: begin
        case (cnt[2:0])
          3'd0:    tx_next = {2'b01, cmd};
          3'd1:    tx_next = cmd_arg[31:24];
          3'd2:    tx_next = cmd_arg[23:16];
          3'd3:    tx_next = cmd_arg[15:8];
          3'd4:    tx_next = cmd_arg[7:0];
          default: tx_next = {crc7, 1'b1};
        endcase
      end
      sd_pkg::st_wtoken: tx_next = cnt[0] ? 8'hfe : 8'hff;
      sd_pkg::st_wdata:  tx_next = bus.rdata;
      sd_pkg::st_wcrc:   tx_next = cnt[0] ? crc16[7:0] : crc16[15:8];
      default: ;
    endcase
  end

  // CRCs restart in every state that precedes a frame or a data block
  assign crc_clear = state inside {sd_pkg::st_idle, sd_pkg::st_init, sd_pkg::st_r1,
                                   sd_pkg::st_token, sd_pkg::st_wtoken};

  sd_crc crc (
    .clock_100M(clock_100M),
    .clear(crc_clear),
    .data_in(state == sd_pkg::st_rdata ? rx : tx_next),
    .crc7_en(launch && state == sd_pkg::st_cmd && cnt < 13'd5),
    .crc16_en((launch && state == sd_pkg::st_wdata) ||
              (spi.done && state == sd_pkg::st_rdata)),
    .crc7(crc7),
    .crc16(crc16)
  );

  always_ff @(posedge clock_100M) begin
    if (state == sd_pkg::st_idle && op_valid) addr_q <= block_addr;
    if (spi.done) last_rx <= rx;
  end

  always_ff @(posedge clock_100M) begin
    if (reset) begin
      state <= sd_pkg::st_init;
      cmd <= sd_pkg::cmd0;
      cnt <= '0;
      retry <= '0;
      pending <= 1'b0;
      fast <= 1'b0;
      init_done <= 1'b0;
      init_error <= 1'b0;
      resp_error <= 1'b0;
      timeout_error <= 1'b0;
      crc_error <= 1'b0;
    end else begin
      if (launch) pending <= 1'b1;
      if (spi.done) pending <= 1'b0;

      if (state == sd_pkg::st_idle && op_valid) begin
        if (op == sd_pkg::op_read) cmd <= sd_pkg::cmd17;
        else cmd <= sd_pkg::cmd24;
        state <= sd_pkg::st_cmd;
        cnt <= '0;
        resp_error <= 1'b0;
        timeout_error <= 1'b0;
        crc_error <= 1'b0;
      end

      if (spi.done) begin
        cnt <= cnt + 13'd1;
        case (state)
          sd_pkg::st_init: begin
            if (cnt == 13'(init_bytes - 1)) begin
              state <= sd_pkg::st_cmd;
              cnt <= '0;
            end
          end
          sd_pkg::st_cmd: begin
            if (cnt == 13'd5) begin
              state <= sd_pkg::st_r1;
              cnt <= '0;
            end
          end
          sd_pkg::st_r1: begin
            if (!rx[7]) begin
              cnt <= '0;
              state <= sd_pkg::st_cmd;
              case (cmd)
                sd_pkg::cmd0: begin
                  cmd <= sd_pkg::cmd8;
                  if (rx != 8'h01) init_error <= 1'b1;
                end
                sd_pkg::cmd8: begin
                  state <= sd_pkg::st_r7;
                  if (rx != 8'h01) init_error <= 1'b1;
                end
                sd_pkg::cmd55: begin
                  cmd <= sd_pkg::acmd41;
                  if (rx[7:1] != 7'd0) init_error <= 1'b1;
                end
                sd_pkg::acmd41: begin
                  if (rx == 8'h00) begin
                    cmd <= sd_pkg::cmd16;
                  end else if (rx == 8'h01 &&
                               retry != 8'(`SD_ACMD41_RETRIES - 1)) begin
                    retry <= retry + 8'd1;
                    cmd <= sd_pkg::cmd55;
                  end else begin
                    init_error <= 1'b1;
                  end
                end
                sd_pkg::cmd16: begin
                  state <= sd_pkg::st_idle;
                  if (rx == 8'h00) begin
                    init_done <= 1'b1;
                    fast <= 1'b1;
                  end else begin
                    init_error <= 1'b1;
                  end
                end
                sd_pkg::cmd17: state <= sd_pkg::st_token;
                default: state <= sd_pkg::st_wtoken;
              endcase
              // A rejected transfer command
              if (init_done && rx != 8'h00) begin
                resp_error <= 1'b1;
                state <= sd_pkg::st_idle;
              end
              // Any init failure parks the FSM
              if (!init_done && cmd != sd_pkg::cmd16 && (rx[7:1] != 7'd0 ||
                  (cmd == sd_pkg::acmd41 && rx == 8'h01 &&
                   retry == 8'(`SD_ACMD41_RETRIES - 1)) ||
                  ((cmd == sd_pkg::cmd0 || cmd == sd_pkg::cmd8) && rx != 8'h01))) begin
                state <= sd_pkg::st_idle;
              end
            end else if (cnt == 13'(`SD_RESP_TIMEOUT - 1)) begin
              state <= sd_pkg::st_idle;
              if (init_done) timeout_error <= 1'b1;
              else init_error <= 1'b1;
            end
          end
          sd_pkg::st_r7: begin
            // Voltage accepted nibble then the 0xAA echo
            if (cnt == 13'd3) begin
              cnt <= '0;
              if (last_rx[3:0] == 4'h1 && rx == 8'haa) begin
                cmd <= sd_pkg::cmd55;
                state <= sd_pkg::st_cmd;
              end else begin
                init_error <= 1'b1;
                state <= sd_pkg::st_idle;
              end
            end
          end
          sd_pkg::st_token: begin
            if (rx == 8'hfe) begin
              state <= sd_pkg::st_rdata;
              cnt <= '0;
            end else if (rx != 8'hff) begin
              resp_error <= 1'b1;
              state <= sd_pkg::st_idle;
            end else if (cnt == 13'(`SD_TOKEN_TIMEOUT - 1)) begin
              timeout_error <= 1'b1;
              state <= sd_pkg::st_idle;
            end
          end
          sd_pkg::st_rdata,
          sd_pkg::st_wdata: begin
            if (cnt == 13'(`SD_BLOCK_BYTES - 1)) begin
              state <= (state == sd_pkg::st_rdata) ? sd_pkg::st_rcrc : sd_pkg::st_wcrc;
              cnt <= '0;
            end
          end
          sd_pkg::st_rcrc: begin
            if (rx != (cnt[0] ? crc16[7:0] : crc16[15:8])) crc_error <= 1'b1;
            if (cnt[0]) state <= sd_pkg::st_idle;
          end
          sd_pkg::st_wtoken: begin
            if (cnt[0]) begin
              state <= sd_pkg::st_wdata;
              cnt <= '0;
            end
          end
          sd_pkg::st_wcrc: begin
            if (cnt[0]) begin
              state <= sd_pkg::st_wresp;
              cnt <= '0;
            end
          end
          sd_pkg::st_wresp: begin
            // Data response token xxx0sss1 is accepted when sss is 010
            if (!rx[4]) begin
              cnt <= '0;
              if (rx[4:0] == 5'h05) begin
                state <= sd_pkg::st_wbusy;
              end else begin
                resp_error <= 1'b1;
                state <= sd_pkg::st_idle;
              end
            end else if (cnt == 13'(`SD_RESP_TIMEOUT - 1)) begin
              timeout_error <= 1'b1;
              state <= sd_pkg::st_idle;
            end
          end
          sd_pkg::st_wbusy: begin
            if (rx != 8'h00) begin
              state <= sd_pkg::st_idle;
            end else if (cnt == 13'(`SD_TOKEN_TIMEOUT - 1)) begin
              timeout_error <= 1'b1;
              state <= sd_pkg::st_idle;
            end
          end
          default: ;
        endcase
      end
    end
  end

endmodule

// File: verilog/sd_crc.sv
`timescale 1ns/1ps

module sd_crc (
  input  logic        clock_100M,
  input  logic        clear,
  input  logic [7:0]  data_in,
  input  logic        crc7_en,
  input  logic        crc16_en,
  output logic [6:0]  crc7,
  output logic [15:0] crc16
);

  function automatic logic [6:0] crc7_next(input logic [6:0] crc, input logic [7:0] d);
    logic [6:0] c;
    logic       fb;
    c = crc;
    for (int i = 7; i >= 0; i--) begin
      fb = c[6] ^ d[i];
      c = {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
    end
    return c;
  endfunction

  function automatic logic [15:0] crc16_next(input logic [15:0] crc, input logic [7:0] d);
    logic [15:0] c;
    logic        fb;
    c = crc;
    for (int i = 7; i >= 0; i--) begin
      fb = c[15] ^ d[i];
      c = {c[14:0], 1'b0} ^ (fb ? 16'h1021 : 16'h0000);
    end
    return c;
  endfunction

  always_ff @(posedge clock_100M) begin
    if (clear) begin
      crc7 <= '0;
      crc16 <= '0;
    end else begin
      if (crc7_en) crc7 <= crc7_next(crc7, data_in);
      if (crc16_en) crc16 <= crc16_next(crc16, data_in);
    end
  end

endmodule

// File: verilog/sd_host_top.sv
`timescale 1ns/1ps

module sd_host_top (
  input  logic        clock_100M,
  input  logic        reset,
  input  logic [11:0] paddr,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  input  logic        miso,
  output logic        cs,
  output logic        sck,
  output logic        mosi
);

  sd_pkg::sd_status_t status;
  sd_pkg::sd_op_t     op;
  logic               op_valid;
  logic [31:0]        block_addr;
  logic [6:0]         buf_addr;
  logic [31:0]        buf_wdata;
  logic [31:0]        buf_rdata;
  logic               buf_we;

  sd_spi_if spi_bus ();
  sd_buf_if buf_bus ();

  sd_apb_regs regs (
    .clock_100M(clock_100M),
    .reset(reset),
    .paddr(paddr),
    .psel(psel),
    .penable(penable),
    .pwrite(pwrite),
    .pwdata(pwdata),
    .status(status),
    .buf_rdata(buf_rdata),
    .prdata(prdata),
    .pready(pready),
    .pslverr(pslverr),
    .op(op),
    .op_valid(op_valid),
    .block_addr(block_addr),
    .buf_addr(buf_addr),
    .buf_wdata(buf_wdata),
    .buf_we(buf_we)
  );

  sd_block_buffer block_buffer (
    .clock_100M(clock_100M),
    .buf_addr(buf_addr),
    .buf_wdata(buf_wdata),
    .buf_we(buf_we),
    .buf_rdata(buf_rdata),
    .bus(buf_bus)
  );

  sd_controller controller (
    .clock_100M(clock_100M),
    .reset(reset),
    .op(op),
    .op_valid(op_valid),
    .block_addr(block_addr),
    .status(status),
    .spi(spi_bus),
    .bus(buf_bus)
  );

  sd_spi_shifter shifter (
    .clock_100M(clock_100M),
    .reset(reset),
    .miso(miso),
    .sck(sck),
    .mosi(mosi),
    .cs(cs),
    .spi(spi_bus)
  );

endmodule

// File: verilog/sd_params.svh
`ifndef SD_PARAMS_SVH
`define SD_PARAMS_SVH

// SCK dividers in clock_100M cycles per period
`define SD_SLOW_DIV 250
`define SD_FAST_DIV 4

`define SD_BLOCK_BYTES 512
`define SD_INIT_CLOCKS 80
`define SD_ACMD41_RETRIES 200

// Polling limits counted in bytes
`define SD_RESP_TIMEOUT 16
`define SD_TOKEN_TIMEOUT 4096

`define SD_REG_CTRL 12'h000
`define SD_REG_ADDR 12'h004
`define SD_REG_STATUS 12'h008
`define SD_DATA_BASE 12'h200

`endif

// File: verilog/sd_pkg.sv
package sd_pkg;

  typedef enum logic [5:0] {
    cmd0   = 6'd0,
    cmd8   = 6'd8,
    cmd16  = 6'd16,
    cmd17  = 6'd17,
    cmd24  = 6'd24,
    acmd41 = 6'd41,
    cmd55  = 6'd55
  } sd_cmd_t;

  // STATUS[5:0] with busy in the top bit
  typedef struct packed {
    logic busy;
    logic init_done;
    logic init_error;
    logic resp_error;
    logic timeout_error;
    logic crc_error;
  } sd_status_t;

  typedef enum logic [1:0] {
    op_none  = 2'd0,
    op_read  = 2'd1,
    op_write = 2'd2
  } sd_op_t;

  typedef enum logic [3:0] {
    st_idle,
    st_init,
    st_cmd,
    st_r1,
    st_r7,
    st_token,
    st_rdata,
    st_rcrc,
    st_wtoken,
    st_wdata,
    st_wcrc,
    st_wresp,
    st_wbusy
  } sd_state_t;

endpackage

// File: verilog/sd_spi_if.sv
`timescale 1ns/1ps

interface sd_spi_if;
  logic       start;
  logic       fast;
  logic       cs_active;
  logic [7:0] tx_byte;
  logic [7:0] rx_byte;
  logic       done;

  modport controller (
    output start, fast, cs_active, tx_byte,
    input  rx_byte, done
  );

  modport shifter (
    input  start, fast, cs_active, tx_byte,
    output rx_byte, done
  );
endinterface

// File: verilog/sd_spi_shifter.sv
`timescale 1ns/1ps
`include "sd_params.svh"

module sd_spi_shifter (
  input  logic       clock_100M,
  input  logic       reset,
  input  logic       miso,
  output logic       sck,
  output logic       mosi,
  output logic       cs,
  sd_spi_if.shifter  spi
);

  logic       busy;
  logic [7:0] div_cnt;
  logic [2:0] bit_cnt;
  logic [7:0] shift_reg;
  logic [7:0] term;
  logic [7:0] half;

  assign term = spi.fast ? 8'(`SD_FAST_DIV - 1) : 8'(`SD_SLOW_DIV - 1);
  assign half = spi.fast ? 8'(`SD_FAST_DIV / 2 - 1) : 8'(`SD_SLOW_DIV / 2 - 1);
  assign spi.rx_byte = shift_reg;

  always_ff @(posedge clock_100M) begin
    if (reset) begin
      busy <= 1'b0;
      div_cnt <= '0;
      bit_cnt <= '0;
      sck <= 1'b0;
      mosi <= 1'b1;
      cs <= 1'b1;
      spi.done <= 1'b0;
    end else begin
      cs <= ~spi.cs_active;
      spi.done <= 1'b0;
      if (!busy) begin
        if (spi.start) begin
          busy <= 1'b1;
          div_cnt <= '0;
          bit_cnt <= '0;
          shift_reg <= spi.tx_byte;
          // Mode 0 sets up the first bit before the first rising edge
          mosi <= spi.tx_byte[7];
        end
      end else begin
        div_cnt <= (div_cnt == term) ? 8'd0 : div_cnt + 8'd1;
        if (div_cnt == half) begin
          sck <= 1'b1;
          shift_reg <= {shift_reg[6:0], miso};
        end
        if (div_cnt == term) begin
          sck <= 1'b0;
          bit_cnt <= bit_cnt + 3'd1;
          if (bit_cnt == 3'd7) begin
            busy <= 1'b0;
            spi.done <= 1'b1;
            mosi <= 1'b1;
          end else begin
            mosi <= shift_reg[7];
          end
        end
      end
    end
  end

endmodule
